/* dv/im2col_tb.sv */
`timescale 1ns/100ps
/*
 * im2col testbench with register bus driver, DMA slave model and done pulses
 * reference model of the im2col loop and five directed tests
 */
module im2col_tb;
  import im2col_pkg::*;

  localparam int unsigned NUM_CH          = 2;
  localparam word_t       DMA_BASE        = 32'h0003_0000;
  localparam word_t       CH_SIZE         = 32'h100;
  localparam int unsigned TOTAL_XFERS     = 33; // 1 + 16 + 8 + 4 + 4
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_XFERS * 200 + 2000;

  logic              clk, rst_n;
  logic              reg_valid, reg_write, reg_ready;
  reg_addr_t         reg_addr;
  word_t             reg_wdata, reg_rdata;
  logic              dma_req, dma_gnt, dma_rvalid;
  word_t             dma_addr, dma_wdata;
  logic [NUM_CH-1:0] dma_done;
  logic              irq;

  string cur_test;
  int    err_count = 0;
  int    test_errs, tests_run, tests_failed;
  int    cyc = 0;
  word_t cfg_val [12];          // configuration registers in address order
  word_t exp_off [$], exp_data [$];
  word_t log_ch [$], log_off [$], log_data [$];
  int    last_start [NUM_CH];   // cycle of the first request of the latest use
  int    last_done [NUM_CH];    // cycle of the latest done pulse
  int    use_count [NUM_CH];
  int    pending_done = 0;
  int unsigned gnt_min = 0, gnt_max = 3, done_min = 2, done_max = 10;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  im2col_top #(
    .NUM_DMA_CH    (NUM_CH),
    .DMA_BASE_ADDR (DMA_BASE),
    .DMA_CH_SIZE   (CH_SIZE),
    .FIFO_DEPTH    (4)
  ) u_im2col_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .reg_ready_o  (reg_ready),
    .dma_req_o    (dma_req),
    .dma_addr_o   (dma_addr),
    .dma_wdata_o  (dma_wdata),
    .dma_gnt_i    (dma_gnt),
    .dma_rvalid_i (dma_rvalid),
    .dma_done_i   (dma_done),
    .irq_o        (irq)
  );

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_eq(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      err_count++;
      $display("mismatch: test %s, %s: expected 0x%08h, actual 0x%08h",
               cur_test, what, exp, act);
    end
  endtask

  // one access per cycle, entered and left 1 ns after a rising edge
  task automatic reg_access(input logic wr, input reg_addr_t addr, input word_t wdata,
                            output word_t rdata);
    reg_valid = 1'b1;
    reg_write = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    #1;
    rdata = reg_rdata;
    check_eq("bus ready", 1, reg_ready);
    @(posedge clk);
    #1;
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  // the DUT sees a done pulse at the end of the cycle that carries it
  function automatic bit chan_free(input int j, input int p);
    return (last_start[j] < 0) || (last_done[j] > last_start[j] && last_done[j] < p);
  endfunction

  task automatic send_done(input int ch, input int unsigned d);
    repeat (d) @(posedge clk);
    #1;
    dma_done[ch]  = 1'b1;
    last_done[ch] = cyc;
    pending_done--;
    @(posedge clk);
    #1;
    dma_done[ch] = 1'b0;
  endtask

  task automatic record_write(input word_t ch_w, input word_t off, input word_t data,
                              input int r);
    int ch, lowest, j;
    int unsigned d;
    check_eq("channel in range", 1, ch_w < NUM_CH);
    ch = int'(ch_w);
    if (ch_w < NUM_CH && off == DMA_SRC_PTR) begin
      // the channel was picked in the cycle before its first request
      lowest = -1;
      for (j = NUM_CH - 1; j >= 0; j--) begin
        if (chan_free(j, r - 1)) lowest = j;
      end
      check_eq("chosen channel was free", 1, chan_free(ch, r - 1));
      check_eq("lowest free channel", word_t'(lowest), ch_w);
      last_start[ch] = r;
      use_count[ch]++;
    end
    if (ch_w < NUM_CH && off == DMA_SIZE_D1) begin
      d = $urandom_range(done_max, done_min);
      pending_done++;
      fork
        send_done(ch, d);
      join_none
    end
    log_ch.push_back(ch_w);
    log_off.push_back(off);
    log_data.push_back(data);
  endtask

  initial begin : dma_model
    int unsigned delay;
    int r;
    word_t rel;
    dma_gnt    = 1'b0;
    dma_rvalid = 1'b0;
    dma_done   = '0;
    @(posedge clk);
    #1;
    forever begin
      if (!dma_req) begin
        @(posedge clk);
        #1;
      end else begin
        r     = cyc;
        delay = $urandom_range(gnt_max, gnt_min);
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        dma_gnt = 1'b1;
        rel     = dma_addr - DMA_BASE;
        record_write(rel / CH_SIZE, rel % CH_SIZE, dma_wdata, r);
        @(posedge clk);
        #1;
        dma_gnt    = 1'b0;
        dma_rvalid = 1'b1; // response one cycle after the grant
        @(posedge clk);
        #1;
        dma_rvalid = 1'b0;
      end
    end
  end

  task automatic expect_write(input word_t off, input word_t data);
    exp_off.push_back(off);
    exp_data.push_back(data);
  endtask

  // cc on the outer loop and batch on the inner loop
  task automatic build_expected();
    word_t iw, ih, fw, fh, nch, nb, s1, s2, npw, nph;
    word_t cc, b, k, w_off, h_off, c, idx;
    exp_off.delete();
    exp_data.delete();
    iw  = cfg_val[2];
    ih  = cfg_val[3];
    fw  = cfg_val[4];
    fh  = cfg_val[5];
    nch = cfg_val[6];
    nb  = cfg_val[7];
    s1  = cfg_val[8];
    s2  = cfg_val[9];
    npw = cfg_val[10];
    nph = cfg_val[11];
    k   = 0;
    for (cc = 0; cc < nch * fh * fw; cc++) begin
      for (b = 0; b < nb; b++) begin
        w_off = cc % fw;
        h_off = (cc / fw) % fh;
        c     = cc / (fw * fh);
        idx   = ((b * nch + c) * ih + h_off) * iw + w_off;
        expect_write(DMA_SRC_PTR, cfg_val[0] + 4 * idx);
        expect_write(DMA_DST_PTR, cfg_val[1] + 4 * k * npw * nph);
        expect_write(DMA_INC_SRC_D1, 4 * s1);
        expect_write(DMA_INC_SRC_D2, 4 * (s2 * iw - (npw - 1) * s1));
        expect_write(DMA_SIZE_D2, nph);
        expect_write(DMA_SIZE_D1, 4 * npw);
        k++;
      end
    end
  endtask

  task automatic compare_log();
    int n, i;
    n = (exp_off.size() < log_off.size()) ? exp_off.size() : log_off.size();
    check_eq("write count", exp_off.size(), log_off.size());
    for (i = 0; i < n; i++) begin
      check_eq($sformatf("offset of write %0d", i), exp_off[i], log_off[i]);
      check_eq($sformatf("data of write %0d", i), exp_data[i], log_data[i]);
      if (i % 6 != 0) begin
        check_eq($sformatf("channel of write %0d", i), log_ch[i - i % 6], log_ch[i]);
      end
    end
  endtask

  task automatic configure(input word_t src, dst, iw, ih, fw, fh, nch, nb,
                           input word_t s1, s2, npw, nph);
    word_t rd;
    int i;
    cfg_val = '{src, dst, iw, ih, fw, fh, nch, nb, s1, s2, npw, nph};
    for (i = 0; i < 12; i++) begin
      reg_access(1'b1, reg_addr_t'(4 * i), cfg_val[i], rd);
    end
  endtask

  task automatic run_job(input word_t ctrl, output bit irq_seen);
    word_t rd;
    log_ch.delete();
    log_off.delete();
    log_data.delete();
    build_expected();
    reg_access(1'b1, REG_CTRL, ctrl, rd);
    @(posedge clk); // STATUS still shows the previous job during the start cycle
    #1;
    irq_seen = 1'b0;
    rd       = '0;
    while (!rd[1]) begin
      irq_seen = irq_seen | irq;
      reg_access(1'b0, REG_STATUS, '0, rd);
    end
    irq_seen = irq_seen | irq;
    check_eq("status after job", 32'h2, rd);
  endtask

  task automatic wait_channels_idle();
    while (pending_done != 0) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_errs) begin
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, err_count - test_errs);
    end
  endtask

  task automatic test_readback();
    word_t rd, pat;
    int i;
    start_test("register readback");
    for (i = 0; i < 12; i++) begin
      pat = 32'hA5C3_0000 ^ (word_t'(i) * 32'h0001_0203) ^ (word_t'(i) << 28);
      reg_access(1'b1, reg_addr_t'(4 * i), pat, rd);
      reg_access(1'b0, reg_addr_t'(4 * i), '0, rd);
      check_eq($sformatf("readback of register 0x%02h", 4 * i), pat, rd);
    end
    reg_access(1'b0, REG_STATUS, '0, rd);
    check_eq("status after reset", 32'h0, rd);
    reg_access(1'b0, 8'h3C, '0, rd);
    check_eq("unmapped register", 32'h0, rd);
    end_test();
  endtask

  task automatic test_single();
    bit irq_seen;
    start_test("single transfer");
    configure(32'h1000_0000, 32'h2000_0000, 8, 8, 1, 1, 1, 1, 1, 1, 4, 3);
    run_job(32'h1, irq_seen);
    compare_log();
    wait_channels_idle();
    end_test();
  endtask

  task automatic test_full();
    bit irq_seen;
    start_test("full im2col job");
    configure(32'h1000_0100, 32'h2000_0000, 9, 9, 2, 2, 2, 2, 2, 2, 4, 4);
    run_job(32'h1, irq_seen);
    compare_log();
    wait_channels_idle();
    end_test();
  endtask

  task automatic test_backpressure();
    bit irq_seen;
    int j;
    start_test("back-pressure");
    gnt_min  = 2;
    gnt_max  = 6;
    done_min = 40; // long enough that both channels end up busy
    done_max = 60;
    for (j = 0; j < NUM_CH; j++) begin
      use_count[j] = 0;
    end
    configure(32'h1100_0000, 32'h2200_0000, 6, 6, 2, 2, 1, 2, 1, 1, 5, 5);
    run_job(32'h1, irq_seen);
    compare_log();
    check_eq("channel 1 used while channel 0 busy", 1, use_count[1] > 0);
    wait_channels_idle();
    gnt_min  = 0;
    gnt_max  = 3;
    done_min = 2;
    done_max = 10;
    end_test();
  endtask

  task automatic test_irq();
    word_t rd;
    bit irq_seen;
    start_test("interrupt");
    configure(32'h1000_0000, 32'h2400_0000, 6, 6, 2, 1, 1, 2, 1, 1, 3, 3);
    run_job(32'h3, irq_seen);
    compare_log();
    check_eq("irq after done", 1, irq);
    reg_access(1'b0, REG_IFR, '0, rd);
    check_eq("interrupt flag read", 32'h1, rd);
    check_eq("irq after flag read", 0, irq);
    wait_channels_idle();
    run_job(32'h1, irq_seen);
    compare_log();
    check_eq("irq with irq_en clear", 0, irq_seen);
    wait_channels_idle();
    end_test();
  endtask

  initial begin : main
    int j;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    tests_run    = 0;
    tests_failed = 0;
    for (j = 0; j < NUM_CH; j++) begin
      last_start[j] = -1;
      last_done[j]  = -1;
      use_count[j]  = 0;
    end
    void'($urandom(32'h7f5e_c9bb));
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    test_readback();
    test_single();
    test_full();
    test_backpressure();
    test_irq();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/100ps
/*
 * testbench clock (4 ns period) and active-low reset held for 5 cycles
 */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #1 rst_no = 1'b1; // release just after an edge, like every other input
  end

endmodule

/* hw/im2col_addr_gen.sv */
`timescale 1ns/100ps
/*
 * im2col loop walker producing one descriptor per (channel-column, batch)
 * index and pointer arithmetic over a few registered stages
 */
module im2col_addr_gen (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  im2col_cfg_if.gen                cfg,
  output im2col_pkg::im2col_desc_t desc_o,
  output logic                     desc_valid_o,
  input  logic                     desc_ready_i
);
  import im2col_pkg::*;

  typedef enum logic [2:0] {
    GEN_IDLE,
    GEN_ROW,
    GEN_IDX,
    GEN_PTR,
    GEN_OUT
  } gen_state_e;

  gen_state_e   state_q;
  word_t        b_q, w_off_q, h_off_q, c_q;
  word_t        dst_q, inc_q, patch_bytes_q;
  word_t        row_q, idx_q;
  im2col_desc_t desc_q;
  logic         last_xfer;

  // batch is the inner loop, then w_off, h_off and channel
  assign last_xfer = (b_q == cfg.batch - 1) && (w_off_q == cfg.fw - 1) &&
                     (h_off_q == cfg.fh - 1) && (c_q == cfg.num_ch - 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= GEN_IDLE;
      b_q           <= '0;
      w_off_q       <= '0;
      h_off_q       <= '0;
      c_q           <= '0;
      dst_q         <= '0;
      inc_q         <= '0;
      patch_bytes_q <= '0;
    end else begin
      case (state_q)
        GEN_IDLE: begin
          if (cfg.start) begin
            b_q     <= '0;
            w_off_q <= '0;
            h_off_q <= '0;
            c_q     <= '0;
            dst_q   <= cfg.dst_ptr;
            // the row jump is the same for every transfer of a job
            inc_q <= ELEM_BYTES * (cfg.stride_d2 * cfg.iw -
                                   (cfg.n_patch_w - 1) * cfg.stride_d1);
            patch_bytes_q <= ELEM_BYTES * cfg.n_patch_w * cfg.n_patch_h;
            state_q       <= GEN_ROW;
          end
        end
        GEN_ROW: state_q <= GEN_IDX;
        GEN_IDX: state_q <= GEN_PTR;
        GEN_PTR: state_q <= GEN_OUT;
        GEN_OUT: begin
          if (desc_ready_i) begin  // a full FIFO keeps us parked here
            dst_q <= dst_q + patch_bytes_q;
            if (last_xfer) begin
              state_q <= GEN_IDLE;
            end else begin
              state_q <= GEN_ROW;
              if (b_q == cfg.batch - 1) begin
                b_q <= '0;
                if (w_off_q == cfg.fw - 1) begin
                  w_off_q <= '0;
                  if (h_off_q == cfg.fh - 1) begin
                    h_off_q <= '0;
                    c_q     <= c_q + 1;
                  end else begin
                    h_off_q <= h_off_q + 1;
                  end
                end else begin
                  w_off_q <= w_off_q + 1;
                end
              end else begin
                b_q <= b_q + 1;
              end
            end
          end
        end
        default: state_q <= GEN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      GEN_ROW: row_q <= (b_q * cfg.num_ch + c_q) * cfg.ih + h_off_q;
      GEN_IDX: idx_q <= row_q * cfg.iw + w_off_q; // element index in the input tensor
      GEN_PTR: begin
        desc_q.src_ptr    <= cfg.src_ptr + ELEM_BYTES * idx_q;
        desc_q.dst_ptr    <= dst_q;
        desc_q.inc_src_d2 <= inc_q;
        desc_q.last       <= last_xfer;
      end
      default: begin
      end
    endcase
  end

  assign desc_o       = desc_q;
  assign desc_valid_o = (state_q == GEN_OUT);

endmodule

/* hw/im2col_cfg_if.sv */
`timescale 1ns/100ps
/*
 * job configuration bundle from the register file to the datapath
 */
interface im2col_cfg_if;
  import im2col_pkg::*;

  word_t src_ptr, dst_ptr;
  word_t iw, ih, fw, fh;
  word_t num_ch, batch;
  word_t stride_d1, stride_d2;
  word_t n_patch_w, n_patch_h;
  logic  start;

  modport cfg (output src_ptr, dst_ptr, iw, ih, fw, fh, num_ch, batch,
               stride_d1, stride_d2, n_patch_w, n_patch_h, start);
  modport gen (input src_ptr, dst_ptr, iw, ih, fw, fh, num_ch, batch,
               stride_d1, stride_d2, n_patch_w, n_patch_h, start);
  modport prog (input stride_d1, n_patch_w, n_patch_h);

endinterface

/* hw/im2col_desc_fifo.sv */
`timescale 1ns/100ps
/*
 * fall-through descriptor FIFO on a circular buffer
 */
module im2col_desc_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  im2col_pkg::im2col_desc_t in_i,
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  output im2col_pkg::im2col_desc_t out_o,
  output logic                     out_valid_o,
  input  logic                     out_ready_i
);
  import im2col_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  im2col_desc_t     mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             empty, full, push, pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == CNT_W'(FIFO_DEPTH));

  assign in_ready_o  = !full;
  assign out_valid_o = !empty || in_valid_i;
  assign out_o       = empty ? in_i : mem_q[rd_ptr_q]; // bypass when nothing is stored

  // a descriptor taken straight through the bypass is never stored
  assign push = in_valid_i && !full && !(empty && out_ready_i);
  assign pop  = !empty && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_i;
    end
  end

  // a descriptor refused while full stays on offer, unchanged, until it is taken
  a_offer_held_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (full && in_valid_i) |=> (in_valid_i && $stable(in_i)));

endmodule

/* hw/im2col_dma_prog.sv */
`timescale 1ns/100ps
/*
 * DMA channel busy tracker and lowest-free-channel choice
 * six-write channel programming over the req/gnt/rvalid master port
 */
module im2col_dma_prog #(
  parameter int unsigned       NUM_DMA_CH    = 2,
  parameter im2col_pkg::word_t DMA_BASE_ADDR = 32'h0,
  parameter im2col_pkg::word_t DMA_CH_SIZE   = 32'h100
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  im2col_cfg_if.prog               cfg,
  input  im2col_pkg::im2col_desc_t desc_i,
  input  logic                     desc_valid_i,
  output logic                     desc_ready_o,
  output logic                     dma_req_o,
  output im2col_pkg::word_t        dma_addr_o,
  output im2col_pkg::word_t        dma_wdata_o,
  input  logic                     dma_gnt_i,
  input  logic                     dma_rvalid_i,
  input  logic [NUM_DMA_CH-1:0]    dma_done_i,
  output logic                     done_o
);
  import im2col_pkg::*;

  localparam int unsigned CH_W = (NUM_DMA_CH > 1) ? $clog2(NUM_DMA_CH) : 1;

  typedef enum logic [1:0] {
    PROG_IDLE,
    PROG_REQ,
    PROG_WAIT
  } prog_state_e;

  prog_state_e           state_q;
  im2col_desc_t          desc_q;
  logic [2:0]            wr_idx_q;  // which of the six channel registers is next
  logic [CH_W-1:0]       chan_q, free_ch;
  logic [NUM_DMA_CH-1:0] ch_busy_q;
  logic                  all_busy, pop, done_q;
  word_t                 reg_off;

  // scanning downwards leaves the lowest free channel selected
  always_comb begin
    free_ch = '0;
    for (int i = NUM_DMA_CH - 1; i >= 0; i--) begin
      if (!ch_busy_q[i]) begin
        free_ch = CH_W'(i);
      end
    end
  end

  assign all_busy     = &ch_busy_q;
  assign desc_ready_o = (state_q == PROG_IDLE) && !all_busy;
  assign pop          = desc_valid_i && desc_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= PROG_IDLE;
      wr_idx_q  <= '0;
      chan_q    <= '0;
      ch_busy_q <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      for (int i = 0; i < NUM_DMA_CH; i++) begin
        if (dma_done_i[i]) begin
          ch_busy_q[i] <= 1'b0;
        end
      end
      case (state_q)
        PROG_IDLE: begin
          if (pop) begin
            chan_q             <= free_ch;
            ch_busy_q[free_ch] <= 1'b1;
            wr_idx_q           <= '0;
            state_q            <= PROG_REQ;
          end
        end
        PROG_REQ: begin
          if (dma_gnt_i) begin
            state_q <= PROG_WAIT;
          end
        end
        PROG_WAIT: begin
          if (dma_rvalid_i) begin
            if (wr_idx_q == 3'd5) begin
              state_q <= PROG_IDLE;
              done_q  <= desc_q.last; // SIZE_D1 of the final transfer has landed
            end else begin
              wr_idx_q <= wr_idx_q + 3'd1;
              state_q  <= PROG_REQ;
            end
          end
        end
        default: state_q <= PROG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop) begin
      desc_q <= desc_i;
    end
  end

  // SIZE_D1 goes last since writing it kicks off the channel
  always_comb begin
    case (wr_idx_q)
      3'd0: begin
        reg_off     = DMA_SRC_PTR;
        dma_wdata_o = desc_q.src_ptr;
      end
      3'd1: begin
        reg_off     = DMA_DST_PTR;
        dma_wdata_o = desc_q.dst_ptr;
      end
      3'd2: begin
        reg_off     = DMA_INC_SRC_D1;
        dma_wdata_o = ELEM_BYTES * cfg.stride_d1;
      end
      3'd3: begin
        reg_off     = DMA_INC_SRC_D2;
        dma_wdata_o = desc_q.inc_src_d2;
      end
      3'd4: begin
        reg_off     = DMA_SIZE_D2;
        dma_wdata_o = cfg.n_patch_h;
      end
      default: begin
        reg_off     = DMA_SIZE_D1;
        dma_wdata_o = ELEM_BYTES * cfg.n_patch_w;
      end
    endcase
  end

  assign dma_addr_o = DMA_BASE_ADDR + word_t'(chan_q) * DMA_CH_SIZE + reg_off;
  assign dma_req_o  = (state_q == PROG_REQ);
  assign done_o     = done_q;

  // address and data must hold until the slave grants
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dma_req_o && !dma_gnt_i) |=> (dma_req_o && $stable(dma_addr_o) && $stable(dma_wdata_o)));

endmodule

/* hw/im2col_pkg.sv */
/*
 * shared word and descriptor types for the im2col peripheral
 * register map of the peripheral and DMA channel register offsets
 */
package im2col_pkg;

  typedef logic [31:0] word_t;

  localparam int unsigned REG_AW = 8;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // configuration registers occupy consecutive words up to CTRL
  localparam reg_addr_t REG_SRC_PTR   = 8'h00;
  localparam reg_addr_t REG_DST_PTR   = 8'h04;
  localparam reg_addr_t REG_IW        = 8'h08;
  localparam reg_addr_t REG_IH        = 8'h0C;
  localparam reg_addr_t REG_FW        = 8'h10;
  localparam reg_addr_t REG_FH        = 8'h14;
  localparam reg_addr_t REG_NUM_CH    = 8'h18;
  localparam reg_addr_t REG_BATCH     = 8'h1C;
  localparam reg_addr_t REG_STRIDE_D1 = 8'h20;
  localparam reg_addr_t REG_STRIDE_D2 = 8'h24;
  localparam reg_addr_t REG_N_PATCH_W = 8'h28;
  localparam reg_addr_t REG_N_PATCH_H = 8'h2C;
  localparam reg_addr_t REG_CTRL      = 8'h30; // bit0 start, bit1 irq_en
  localparam reg_addr_t REG_STATUS    = 8'h34; // bit0 busy, bit1 done
  localparam reg_addr_t REG_IFR       = 8'h38; // bit0 flag, cleared on read

  // offsets inside one DMA channel
  localparam word_t DMA_SRC_PTR    = 32'h0;
  localparam word_t DMA_DST_PTR    = 32'h4;
  localparam word_t DMA_SIZE_D1    = 32'hC;
  localparam word_t DMA_SIZE_D2    = 32'h10;
  localparam word_t DMA_INC_SRC_D1 = 32'h18;
  localparam word_t DMA_INC_SRC_D2 = 32'h1C;

  localparam word_t ELEM_BYTES = 32'd4; // elements are always full words

  typedef struct packed {
    word_t src_ptr;
    word_t dst_ptr;
    word_t inc_src_d2;
    logic  last;       // final transfer of the job
  } im2col_desc_t;

endpackage

/* hw/im2col_regs.sv */
`timescale 1ns/100ps
/*
 * register file with same-cycle bus response
 * start pulse, busy/done status and interrupt flag
 */
module im2col_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  im2col_pkg::reg_addr_t reg_addr_i,
  input  im2col_pkg::word_t     reg_wdata_i,
  output im2col_pkg::word_t     reg_rdata_o,
  output logic                  reg_ready_o,
  input  logic                  done_i,
  output logic                  irq_o,
  im2col_cfg_if.cfg             cfg
);
  import im2col_pkg::*;

  localparam int unsigned NUM_CFG = REG_CTRL / 4;

  word_t cfg_q [NUM_CFG];
  logic  wr_en, rd_en, cfg_hit, ctrl_wr;
  logic  start_q, busy_q, done_q, irq_en_q, ifr_q;

  assign wr_en   = reg_valid_i && reg_write_i;
  assign rd_en   = reg_valid_i && !reg_write_i;
  assign cfg_hit = (reg_addr_i < REG_CTRL) && (reg_addr_i[1:0] == 2'b00);
  assign ctrl_wr = wr_en && (reg_addr_i == REG_CTRL);

  assign reg_ready_o = reg_valid_i; // every access completes in its own cycle

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_CFG; i++) begin
        cfg_q[i] <= '0;
      end
    end else if (wr_en && cfg_hit) begin
      cfg_q[reg_addr_i[5:2]] <= reg_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q  <= 1'b0;
      irq_en_q <= 1'b0;
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      ifr_q    <= 1'b0;
    end else begin
      // a second start while a job runs is ignored
      start_q <= ctrl_wr && reg_wdata_i[0] && !busy_q && !start_q;
      if (ctrl_wr) begin
        irq_en_q <= reg_wdata_i[1];
      end
      if (start_q) begin
        busy_q <= 1'b1;
        done_q <= 1'b0;
      end else if (done_i) begin
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
      if (done_i && irq_en_q) begin
        ifr_q <= 1'b1;
      end else if (rd_en && reg_addr_i == REG_IFR) begin
        ifr_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rdata_o = '0;
    if (cfg_hit) begin
      reg_rdata_o = cfg_q[reg_addr_i[5:2]];
    end else begin
      case (reg_addr_i)
        REG_CTRL:   reg_rdata_o = {30'b0, irq_en_q, 1'b0}; // start reads back as zero
        REG_STATUS: reg_rdata_o = {30'b0, done_q, busy_q};
        REG_IFR:    reg_rdata_o = {31'b0, ifr_q};
        default:    reg_rdata_o = '0;
      endcase
    end
  end

  assign cfg.src_ptr   = cfg_q[REG_SRC_PTR[5:2]];
  assign cfg.dst_ptr   = cfg_q[REG_DST_PTR[5:2]];
  assign cfg.iw        = cfg_q[REG_IW[5:2]];
  assign cfg.ih        = cfg_q[REG_IH[5:2]];
  assign cfg.fw        = cfg_q[REG_FW[5:2]];
  assign cfg.fh        = cfg_q[REG_FH[5:2]];
  assign cfg.num_ch    = cfg_q[REG_NUM_CH[5:2]];
  assign cfg.batch     = cfg_q[REG_BATCH[5:2]];
  assign cfg.stride_d1 = cfg_q[REG_STRIDE_D1[5:2]];
  assign cfg.stride_d2 = cfg_q[REG_STRIDE_D2[5:2]];
  assign cfg.n_patch_w = cfg_q[REG_N_PATCH_W[5:2]];
  assign cfg.n_patch_h = cfg_q[REG_N_PATCH_H[5:2]];
  assign cfg.start     = start_q;

  assign irq_o = ifr_q;

  // a done pulse from the datapath can only end a job that is running
  a_done_only_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> busy_q);

endmodule

/* hw/im2col_top.sv */
`timescale 1ns/100ps
/*
 * im2col smart peripheral top level
 * register file, address generator, descriptor FIFO and DMA programmer
 */
module im2col_top #(
  parameter int unsigned       NUM_DMA_CH    = 2,
  parameter im2col_pkg::word_t DMA_BASE_ADDR = 32'h0003_0000,
  parameter im2col_pkg::word_t DMA_CH_SIZE   = 32'h100,
  parameter int unsigned       FIFO_DEPTH    = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  reg_valid_i,
  input  logic                  reg_write_i,
  input  im2col_pkg::reg_addr_t reg_addr_i,
  input  im2col_pkg::word_t     reg_wdata_i,
  output im2col_pkg::word_t     reg_rdata_o,
  output logic                  reg_ready_o,
  output logic                  dma_req_o,
  output im2col_pkg::word_t     dma_addr_o,
  output im2col_pkg::word_t     dma_wdata_o,
  input  logic                  dma_gnt_i,
  input  logic                  dma_rvalid_i,
  input  logic [NUM_DMA_CH-1:0] dma_done_i,
  output logic                  irq_o
);
  import im2col_pkg::*;

  im2col_desc_t gen_desc, prog_desc;
  logic         gen_valid, gen_ready;
  logic         prog_valid, prog_ready;
  logic         job_done;

  im2col_cfg_if u_cfg_if ();

  im2col_regs u_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ready_o (reg_ready_o),
    .done_i      (job_done),
    .irq_o       (irq_o),
    .cfg         (u_cfg_if.cfg)
  );

  im2col_addr_gen u_addr_gen (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg          (u_cfg_if.gen),
    .desc_o       (gen_desc),
    .desc_valid_o (gen_valid),
    .desc_ready_i (gen_ready)
  );

  im2col_desc_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_desc_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_i        (gen_desc),
    .in_valid_i  (gen_valid),
    .in_ready_o  (gen_ready),
    .out_o       (prog_desc),
    .out_valid_o (prog_valid),
    .out_ready_i (prog_ready)
  );

  im2col_dma_prog #(
    .NUM_DMA_CH    (NUM_DMA_CH),
    .DMA_BASE_ADDR (DMA_BASE_ADDR),
    .DMA_CH_SIZE   (DMA_CH_SIZE)
  ) u_dma_prog (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cfg          (u_cfg_if.prog),
    .desc_i       (prog_desc),
    .desc_valid_i (prog_valid),
    .desc_ready_o (prog_ready),
    .dma_req_o    (dma_req_o),
    .dma_addr_o   (dma_addr_o),
    .dma_wdata_o  (dma_wdata_o),
    .dma_gnt_i    (dma_gnt_i),
    .dma_rvalid_i (dma_rvalid_i),
    .dma_done_i   (dma_done_i),
    .done_o       (job_done)
  );

endmodule

/* project.f */
hw/im2col_pkg.sv
hw/im2col_cfg_if.sv
hw/im2col_regs.sv
hw/im2col_addr_gen.sv
hw/im2col_desc_fifo.sv
hw/im2col_dma_prog.sv
hw/im2col_top.sv
dv/tb_clk_gen.sv
dv/im2col_tb.sv
